// ==== verilog/rv_core_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32I core package
// Shared types, bus records and opcodes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package rv_core_pkg;

  typedef logic [31:0] pc_t;
  typedef logic [31:0] instr_raw_t;
  typedef logic [4:0]  reg_addr_t;

  // Two views of the same instruction word
  typedef struct packed {
    logic [6:0] funct7;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    reg_addr_t  rd;
    logic [6:0] opcode;
  } r_type_t;

  typedef struct packed {
    logic [11:0] imm12;
    reg_addr_t   rs1;
    logic [2:0]  funct3;
    reg_addr_t   rd;
    logic [6:0]  opcode;
  } i_type_t;

  typedef union packed {
    r_type_t r_type;
    i_type_t i_type;
  } instr_u;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_PASS_B,
    ALU_LINK
  } alu_op_e;

  // Queue entry, fetch to decode
  typedef struct packed {
    pc_t        pc;
    instr_raw_t instr;
  } fetch_item_t;

  typedef struct packed {
    pc_t         pc;
    alu_op_e     alu_op;
    reg_addr_t   rd;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    logic        use_imm;
    logic [31:0] imm;
  } dec_item_t;

  typedef struct packed {
    pc_t         pc;
    reg_addr_t   rd;
    logic [31:0] data;
  } res_item_t;

  typedef struct packed {
    logic        valid;
    pc_t         pc;
    reg_addr_t   rd;
    logic [31:0] data;
  } retire_t;

  // Wishbone classic, master and slave sides
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic [31:0] adr;
  } wb_mst_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wb_slv_t;

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  localparam logic [2:0] F3_ADD = 3'b000;
  localparam logic [2:0] F3_XOR = 3'b100;
  localparam logic [2:0] F3_OR  = 3'b110;
  localparam logic [2:0] F3_AND = 3'b111;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_SUB  = 7'b0100000;

endpackage

`default_nettype wire

// ==== verilog/instr_queue.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction queue
// Circular buffer of fetched pc/word pairs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module instr_queue #(
  parameter int QUEUE_DEPTH = 2
) (
  input  wire                              clk,
  input  wire                              arst_n_i,
  input  wire                              clear_i,
  input  wire                              write_i,
  input  wire rv_core_pkg::fetch_item_t    data_i,
  input  wire                              read_i,
  output rv_core_pkg::fetch_item_t         data_o,
  output logic                             empty_o,
  output logic [$clog2(QUEUE_DEPTH+1)-1:0] level_o
);
  import rv_core_pkg::*;

  localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int LVL_W = $clog2(QUEUE_DEPTH + 1);

  fetch_item_t      slots [QUEUE_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [LVL_W-1:0] level;
  logic             full;

  // Wrap at the last slot, depth need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    ptr_inc = (ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign data_o  = slots[rd_ptr];
  assign empty_o = (level == '0);
  assign full    = (level == LVL_W'(QUEUE_DEPTH));
  assign level_o = level;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
    end else if (clear_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
    end else begin
      if (write_i) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (read_i) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      if (write_i && !read_i) begin
        level <= level + 1'b1;
      end else if (read_i && !write_i) begin
        level <= level - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (write_i && !clear_i) begin
      slots[wr_ptr] <= data_i;
    end
  end

  // Fetch must reserve a slot before it launches a bus transfer
  assert property (@(posedge clk) disable iff (!arst_n_i)
    (write_i && !clear_i) |-> !full);
  assert property (@(posedge clk) disable iff (!arst_n_i)
    read_i |-> !empty_o);

endmodule

`default_nettype wire

// ==== verilog/fetch.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fetch stage
// Wishbone master feeding the instr queue
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module fetch #(
  parameter int               QUEUE_DEPTH = 2,
  parameter rv_core_pkg::pc_t BOOT_ADDR   = '0
) (
  input  wire                          clk,
  input  wire                          arst_n_i,
  // Instruction bus
  output rv_core_pkg::wb_mst_t         wb_o,
  input  wire rv_core_pkg::wb_slv_t    wb_i,
  // Jump request from execute
  input  wire                          redirect_i,
  input  wire rv_core_pkg::pc_t        redirect_pc_i,
  // To decode
  output logic                         fetch_valid_o,
  input  wire                          fetch_ready_i,
  output rv_core_pkg::fetch_item_t     fetch_item_o
);
  import rv_core_pkg::*;

  localparam int LVL_W = $clog2(QUEUE_DEPTH + 1);

  pc_t              req_pc;
  pc_t              tgt_pc;
  logic             busy;
  logic             discard;
  logic             ack;
  logic             q_write;
  logic             q_read;
  logic             q_empty;
  logic [LVL_W-1:0] q_level;
  logic [LVL_W:0]   level_next;
  fetch_item_t      q_wdata;

  // Cyc and stb rise together and hold until ack
  always_comb begin
    wb_o.cyc = busy;
    wb_o.stb = busy;
    wb_o.adr = req_pc;
  end

  assign ack = busy && wb_i.ack;

  // Words of the old stream are dropped, both on the redirect and after it
  assign q_write = ack && !discard && !redirect_i;
  assign q_wdata = '{pc: req_pc, instr: wb_i.dat};

  assign fetch_valid_o = !q_empty;
  assign q_read        = fetch_valid_o && fetch_ready_i;

  assign level_next = {1'b0, q_level} + (LVL_W+1)'(q_write) - (LVL_W+1)'(q_read);

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      req_pc  <= BOOT_ADDR;
      busy    <= 1'b0;
      discard <= 1'b0;
    end else if (busy && !wb_i.ack) begin
      // Address must stay put, so only remember where to go next
      if (redirect_i) begin
        discard <= 1'b1;
      end
    end else if (redirect_i) begin
      req_pc  <= redirect_pc_i;
      busy    <= 1'b1;
      discard <= 1'b0;
    end else if (busy && discard) begin
      req_pc  <= tgt_pc;
      busy    <= 1'b1;
      discard <= 1'b0;
    end else begin
      if (busy) begin
        req_pc <= req_pc + 32'd4;
      end
      busy <= (level_next < (LVL_W+1)'(QUEUE_DEPTH));
    end
  end

  always_ff @(posedge clk) begin
    if (redirect_i) begin
      tgt_pc <= redirect_pc_i;
    end
  end

  instr_queue #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) u_queue (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .clear_i  (redirect_i),
    .write_i  (q_write),
    .data_i   (q_wdata),
    .read_i   (q_read),
    .data_o   (fetch_item_o),
    .empty_o  (q_empty),
    .level_o  (q_level)
  );

  assert property (@(posedge clk) disable iff (!arst_n_i)
    wb_o.stb |-> wb_o.cyc);
  // Classic cycle: request held unchanged until the slave answers
  assert property (@(posedge clk) disable iff (!arst_n_i)
    (wb_o.stb && !wb_i.ack) |=> (wb_o.stb && $stable(wb_o.adr)));

endmodule

`default_nettype wire

// ==== verilog/decode.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decode stage
// Splits words into op, regs and immediate
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module decode (
  input  wire                           clk,
  input  wire                           arst_n_i,
  input  wire                           in_valid_i,
  output logic                          in_ready_o,
  input  wire rv_core_pkg::fetch_item_t in_item_i,
  input  wire                           flush_i,
  output logic                          dec_valid_o,
  output rv_core_pkg::dec_item_t        dec_item_o
);
  import rv_core_pkg::*;

  instr_u      word;
  logic        supported;
  logic [31:0] imm_i;
  logic [31:0] imm_u;
  logic [31:0] imm_j;
  dec_item_t   item;

  // Execute never stalls
  assign in_ready_o = 1'b1;
  assign word       = in_item_i.instr;

  always_comb begin
    imm_i = {{20{word.i_type.imm12[11]}}, word.i_type.imm12};
    imm_u = {word.i_type.imm12, word.i_type.rs1, word.i_type.funct3, 12'h000};
    // J layout is imm[20|10:1|11|19:12]
    imm_j = {{12{word.r_type.funct7[6]}}, word.i_type.rs1, word.i_type.funct3,
             word.r_type.rs2[0], word.r_type.funct7[5:0], word.r_type.rs2[4:1], 1'b0};

    supported    = 1'b0;
    item.pc      = in_item_i.pc;
    item.alu_op  = ALU_ADD;
    item.rd      = word.r_type.rd;
    item.rs1     = word.r_type.rs1;
    item.rs2     = word.r_type.rs2;
    item.use_imm = 1'b0;
    item.imm     = imm_i;

    case (word.r_type.opcode)
      OPC_OP: begin
        supported = 1'b1;
        case ({word.r_type.funct7, word.r_type.funct3})
          {F7_BASE, F3_ADD}: item.alu_op = ALU_ADD;
          {F7_SUB, F3_ADD}:  item.alu_op = ALU_SUB;
          {F7_BASE, F3_XOR}: item.alu_op = ALU_XOR;
          {F7_BASE, F3_OR}:  item.alu_op = ALU_OR;
          {F7_BASE, F3_AND}: item.alu_op = ALU_AND;
          default:           supported   = 1'b0;
        endcase
      end
      OPC_OP_IMM: begin
        supported    = 1'b1;
        item.use_imm = 1'b1;
        case (word.i_type.funct3)
          F3_ADD:  item.alu_op = ALU_ADD;
          F3_XOR:  item.alu_op = ALU_XOR;
          F3_OR:   item.alu_op = ALU_OR;
          F3_AND:  item.alu_op = ALU_AND;
          default: supported   = 1'b0;
        endcase
      end
      OPC_LUI: begin
        supported    = 1'b1;
        item.alu_op  = ALU_PASS_B;
        item.use_imm = 1'b1;
        item.imm     = imm_u;
      end
      OPC_JAL: begin
        supported    = 1'b1;
        item.alu_op  = ALU_LINK;
        item.use_imm = 1'b1;
        item.imm     = imm_j;
      end
      default: begin
        supported = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dec_valid_o <= 1'b0;
    end else begin
      dec_valid_o <= in_valid_i && in_ready_o && supported && !flush_i;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid_i && in_ready_o) begin
      dec_item_o <= item;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/execute.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Execute stage
// Operand forwarding, ALU and JAL redirect
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module execute (
  input  wire                         clk,
  input  wire                         arst_n_i,
  input  wire                         dec_valid_i,
  input  wire rv_core_pkg::dec_item_t dec_item_i,
  // Register file read
  output rv_core_pkg::reg_addr_t      rs1_addr_o,
  output rv_core_pkg::reg_addr_t      rs2_addr_o,
  input  wire [31:0]                  rs1_data_i,
  input  wire [31:0]                  rs2_data_i,
  // Entry not yet written back
  input  wire rv_core_pkg::res_item_t fwd_i,
  input  wire                         fwd_valid_i,
  output logic                        redirect_o,
  output rv_core_pkg::pc_t            redirect_pc_o,
  output logic                        res_valid_o,
  output rv_core_pkg::res_item_t      res_item_o
);
  import rv_core_pkg::*;

  logic [31:0] op_a;
  logic [31:0] rs2_val;
  logic [31:0] op_b;
  logic [31:0] result;

  assign rs1_addr_o = dec_item_i.rs1;
  assign rs2_addr_o = dec_item_i.rs2;

  // x0 is never forwarded
  always_comb begin
    op_a = rs1_data_i;
    if (fwd_valid_i && (fwd_i.rd != '0) && (fwd_i.rd == dec_item_i.rs1)) begin
      op_a = fwd_i.data;
    end
    rs2_val = rs2_data_i;
    if (fwd_valid_i && (fwd_i.rd != '0) && (fwd_i.rd == dec_item_i.rs2)) begin
      rs2_val = fwd_i.data;
    end
    op_b = dec_item_i.use_imm ? dec_item_i.imm : rs2_val;
  end

  always_comb begin
    case (dec_item_i.alu_op)
      ALU_ADD:    result = op_a + op_b;
      ALU_SUB:    result = op_a - op_b;
      ALU_AND:    result = op_a & op_b;
      ALU_OR:     result = op_a | op_b;
      ALU_XOR:    result = op_a ^ op_b;
      ALU_PASS_B: result = op_b;
      ALU_LINK:   result = dec_item_i.pc + 32'd4;
      default:    result = '0;
    endcase
  end

  assign redirect_o    = dec_valid_i && (dec_item_i.alu_op == ALU_LINK);
  assign redirect_pc_o = dec_item_i.pc + dec_item_i.imm;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      res_valid_o <= 1'b0;
    end else begin
      res_valid_o <= dec_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (dec_valid_i) begin
      res_item_o <= '{pc: dec_item_i.pc, rd: dec_item_i.rd, data: result};
    end
  end

  // Fetched pc plus decoded offset must land on a word
  assert property (@(posedge clk) disable iff (!arst_n_i)
    redirect_o |-> (redirect_pc_o[1:0] == 2'b00));

endmodule

`default_nettype wire

// ==== verilog/writeback.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Writeback stage
// Register file and retire report
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module writeback (
  input  wire                         clk,
  input  wire                         arst_n_i,
  input  wire                         res_valid_i,
  input  wire rv_core_pkg::res_item_t res_item_i,
  input  wire rv_core_pkg::reg_addr_t rs1_addr_i,
  input  wire rv_core_pkg::reg_addr_t rs2_addr_i,
  output logic [31:0]                 rs1_data_o,
  output logic [31:0]                 rs2_data_o,
  output rv_core_pkg::res_item_t      fwd_o,
  output logic                        fwd_valid_o,
  output rv_core_pkg::retire_t        retire_o
);
  import rv_core_pkg::*;

  logic [31:0] regs [32];
  logic        retire_valid;
  res_item_t   retire_item;

  // Slot 0 is never written and always reads back as zero
  assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
  assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

  // Result lands in the file at the next edge, until then it is forwarded
  assign fwd_o       = res_item_i;
  assign fwd_valid_o = res_valid_i;

  always_ff @(posedge clk) begin
    if (res_valid_i && (res_item_i.rd != '0)) begin
      regs[res_item_i.rd] <= res_item_i.data;
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      retire_valid <= 1'b0;
    end else begin
      retire_valid <= res_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (res_valid_i) begin
      retire_item <= res_item_i;
    end
  end

  assign retire_o = '{valid: retire_valid, pc: retire_item.pc,
                      rd: retire_item.rd, data: retire_item.data};

endmodule

`default_nettype wire

// ==== verilog/rv_core_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32I core top
// Fetch, decode, execute and writeback
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module rv_core_top #(
  parameter int               QUEUE_DEPTH = 2,
  parameter rv_core_pkg::pc_t BOOT_ADDR   = '0
) (
  input  wire                       clk,
  input  wire                       arst_n_i,
  output rv_core_pkg::wb_mst_t      wb_o,
  input  wire rv_core_pkg::wb_slv_t wb_i,
  output rv_core_pkg::retire_t      retire_o
);
  import rv_core_pkg::*;

  logic        fetch_valid;
  logic        fetch_ready;
  fetch_item_t fetch_item;
  logic        redirect;
  pc_t         redirect_pc;
  logic        dec_valid;
  dec_item_t   dec_item;
  reg_addr_t   rs1_addr;
  reg_addr_t   rs2_addr;
  logic [31:0] rs1_data;
  logic [31:0] rs2_data;
  logic        res_valid;
  res_item_t   res_item;
  res_item_t   fwd_item;
  logic        fwd_valid;

  fetch #(
    .QUEUE_DEPTH (QUEUE_DEPTH),
    .BOOT_ADDR   (BOOT_ADDR)
  ) u_fetch (
    .clk           (clk),
    .arst_n_i      (arst_n_i),
    .wb_o          (wb_o),
    .wb_i          (wb_i),
    .redirect_i    (redirect),
    .redirect_pc_i (redirect_pc),
    .fetch_valid_o (fetch_valid),
    .fetch_ready_i (fetch_ready),
    .fetch_item_o  (fetch_item)
  );

  // Same redirect strobe flushes the word decode is taking
  decode u_decode (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .in_valid_i  (fetch_valid),
    .in_ready_o  (fetch_ready),
    .in_item_i   (fetch_item),
    .flush_i     (redirect),
    .dec_valid_o (dec_valid),
    .dec_item_o  (dec_item)
  );

  execute u_execute (
    .clk           (clk),
    .arst_n_i      (arst_n_i),
    .dec_valid_i   (dec_valid),
    .dec_item_i    (dec_item),
    .rs1_addr_o    (rs1_addr),
    .rs2_addr_o    (rs2_addr),
    .rs1_data_i    (rs1_data),
    .rs2_data_i    (rs2_data),
    .fwd_i         (fwd_item),
    .fwd_valid_i   (fwd_valid),
    .redirect_o    (redirect),
    .redirect_pc_o (redirect_pc),
    .res_valid_o   (res_valid),
    .res_item_o    (res_item)
  );

  writeback u_writeback (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .res_valid_i (res_valid),
    .res_item_i  (res_item),
    .rs1_addr_i  (rs1_addr),
    .rs2_addr_i  (rs2_addr),
    .rs1_data_o  (rs1_data),
    .rs2_data_o  (rs2_data),
    .fwd_o       (fwd_item),
    .fwd_valid_o (fwd_valid),
    .retire_o    (retire_o)
  );

endmodule

`default_nettype wire

// ==== verif/clk_gen.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock and reset generator
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module clk_gen #(
  parameter int PERIOD_NS  = 100,
  parameter int RST_CYCLES = 3
) (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Reset released on a rising edge after the hold period
  initial begin
    arst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    arst_n_o <= 1'b1;
  end

endmodule

`default_nettype wire

// ==== verif/retire_checker.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Retire checker
// Compares retirements with expected list
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module retire_checker #(
  parameter int MAX_EXP = 64
) (
  input  wire                        clk,
  input  wire                        arst_n_i,
  input  wire rv_core_pkg::retire_t  retire_i,
  input  wire [31:0]                 exp_pc_i [MAX_EXP],
  input  wire [4:0]                  exp_rd_i [MAX_EXP],
  input  wire [31:0]                 exp_data_i [MAX_EXP],
  input  var int                     exp_count_i,
  output int                         ret_count_o,
  output int                         err_count_o
);

  initial begin
    ret_count_o = 0;
    err_count_o = 0;
  end

  // Retire port is registered and stable at the rising edge
  always @(posedge clk) begin
    if (arst_n_i && retire_i.valid) begin
      if (ret_count_o >= exp_count_i) begin
        $display("Extra retirement of pc %h after the expected list was complete",
                 retire_i.pc);
        err_count_o <= err_count_o + 1;
      end else if (retire_i.pc !== exp_pc_i[ret_count_o] ||
                   retire_i.rd !== exp_rd_i[ret_count_o] ||
                   retire_i.data !== exp_data_i[ret_count_o]) begin
        $display("FAILED at %0t: retire %0d got pc %h rd %0d data %h,",
                 $time, ret_count_o, retire_i.pc, retire_i.rd, retire_i.data,
                 " expected pc %h rd %0d data %h",
                 exp_pc_i[ret_count_o], exp_rd_i[ret_count_o], exp_data_i[ret_count_o]);
        err_count_o <= err_count_o + 1;
      end
      ret_count_o <= ret_count_o + 1;
    end
  end

endmodule

`default_nettype wire

// ==== verif/tb_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32I core testbench
// Bus slave model, pattern load, watchdog
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tb_top;
  import rv_core_pkg::*;

  localparam int MAX_EXP  = 64;
  localparam int MEM_WRDS = 64;

  logic                clk;
  logic                arst_n;
  wb_mst_t             wb_m;
  wb_slv_t             wb_s = '0;
  retire_t             retire;
  logic [31:0]         pat [256];
  logic [31:0]         imem [MEM_WRDS];
  logic [31:0]         exp_pc [MAX_EXP];
  logic [4:0]          exp_rd [MAX_EXP];
  logic [31:0]         exp_data [MAX_EXP];
  int                  exp_count = 0;
  int                  ret_count;
  int                  err_count;
  int                  limit_cycles = 0;
  logic                loaded = 1'b0;
  logic                timed_out = 1'b0;
  logic [15:0]         lfsr = 16'd16063;
  logic                pending = 1'b0;
  logic [1:0]          wait_cnt = '0;

  // Unmapped words carry a load opcode that decode discards
  function automatic logic [31:0] fill_word(input logic [31:0] adr);
    fill_word = {adr[31:7] ^ adr[24:0], 7'b0000011};
  endfunction

  // 16-bit Fibonacci LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    lfsr_step = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [31:0] bus_read(input logic [31:0] adr);
    if (adr < 32'(MEM_WRDS * 4)) begin
      bus_read = imem[adr[7:2]];
    end else begin
      bus_read = fill_word(adr);
    end
  endfunction

  clk_gen #(
    .PERIOD_NS  (100),
    .RST_CYCLES (3)
  ) u_clk_gen (
    .clk_o    (clk),
    .arst_n_o (arst_n)
  );

  rv_core_top #(
    .QUEUE_DEPTH (2),
    .BOOT_ADDR   (32'h0000_0000)
  ) dut_i (
    .clk      (clk),
    .arst_n_i (arst_n),
    .wb_o     (wb_m),
    .wb_i     (wb_s),
    .retire_o (retire)
  );

  retire_checker #(
    .MAX_EXP (MAX_EXP)
  ) u_checker (
    .clk         (clk),
    .arst_n_i    (arst_n),
    .retire_i    (retire),
    .exp_pc_i    (exp_pc),
    .exp_rd_i    (exp_rd),
    .exp_data_i  (exp_data),
    .exp_count_i (exp_count),
    .ret_count_o (ret_count),
    .err_count_o (err_count)
  );

  // Slave answers after 0 to 3 extra wait cycles drawn from two LFSR bits
  always @(posedge clk) begin
    logic [15:0] s1;
    logic [15:0] s2;
    s1 = lfsr_step(lfsr);
    s2 = lfsr_step(s1);
    if (!arst_n) begin
      wb_s    <= '0;
      pending <= 1'b0;
    end else if (wb_s.ack) begin
      wb_s.ack <= 1'b0;
    end else if (wb_m.cyc && wb_m.stb) begin
      if (!pending) begin
        lfsr <= s2;
        if ({s1[0], s2[0]} == 2'd0) begin
          wb_s <= '{ack: 1'b1, dat: bus_read(wb_m.adr)};
        end else begin
          pending  <= 1'b1;
          wait_cnt <= {s1[0], s2[0]} - 2'd1;
        end
      end else if (wait_cnt == 2'd0) begin
        pending <= 1'b0;
        wb_s    <= '{ack: 1'b1, dat: bus_read(wb_m.adr)};
      end else begin
        wait_cnt <= wait_cnt - 2'd1;
      end
    end
  end

  // Each record is a tag word followed by address and word or by pc, rd and value
  initial begin
    int i;
    for (i = 0; i < 256; i++) begin
      pat[i] = '0;
    end
    for (i = 0; i < MEM_WRDS; i++) begin
      imem[i] = fill_word(32'(i * 4));
    end
    $readmemh("verif/core_patterns.txt", pat);
    i = 0;
    while (i < 252 && pat[i] != 32'd0) begin
      if (pat[i] == 32'd1) begin
        imem[pat[i+1][7:2]] = pat[i+2];
      end else if (exp_count < MAX_EXP) begin
        exp_pc[exp_count]   = pat[i+1];
        exp_rd[exp_count]   = pat[i+2][4:0];
        exp_data[exp_count] = pat[i+3];
        exp_count           = exp_count + 1;
      end
      i = i + 4;
    end
    limit_cycles = 40 * exp_count + 100;
    loaded = 1'b1;
  end

  initial begin
    wait (loaded);
    repeat (limit_cycles) @(posedge clk);
    timed_out = 1'b1;
  end

  initial begin
    int total;
    wait (loaded);
    wait ((ret_count >= exp_count) || timed_out);
    if (!timed_out) begin
      // Drain time so late extra retirements are still caught
      repeat (20) @(posedge clk);
    end
    total = err_count;
    if (timed_out) begin
      $display("Timeout: only %0d of %0d expected retirements were seen",
               ret_count, exp_count);
      total = total + 1;
    end
    $display("Retired %0d of %0d expected, %0d errors", ret_count, exp_count, total);
    if (total == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verif/core_patterns.txt ====
// Tag 1: address, instruction word, unused. Tag 2: pc, rd, value in retire order
// Tag 0 ends the list
1 00000000 00500093 0
1 00000004 FFD00113 0
1 00000008 002081B3 0
1 0000000C 40208233 0
1 00000010 0020F2B3 0
1 00000014 0020E333 0
1 00000018 0020C3B3 0
1 0000001C 12345437 0
1 00000020 0FF44493 0
1 00000024 F004E513 0
1 00000028 7FF47593 0
1 0000002C 00C0066F 0
1 00000030 00100693 0
1 00000034 00002003 0
1 00000038 00708013 0
1 0000003C 00002003 0
1 00000040 00100733 0
1 00000044 00170793 0
1 00000048 00F78833 0
2 00000000 01 00000005
2 00000004 02 FFFFFFFD
2 00000008 03 00000002
2 0000000C 04 00000008
2 00000010 05 00000005
2 00000014 06 FFFFFFFD
2 00000018 07 FFFFFFF8
2 0000001C 08 12345000
2 00000020 09 123450FF
2 00000024 0A FFFFFFFF
2 00000028 0B 00000000
2 0000002C 0C 00000030
2 00000038 00 0000000C
2 00000040 0E 00000005
2 00000044 0F 00000006
2 00000048 10 0000000C
0 0 0 0

// ==== rv_core_top.f ====
verilog/rv_core_pkg.sv
verilog/instr_queue.sv
verilog/fetch.sv
verilog/decode.sv
verilog/execute.sv
verilog/writeback.sv
verilog/rv_core_top.sv
verif/clk_gen.sv
verif/retire_checker.sv
verif/tb_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the core testbench with Verilator, from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_top \
  -f rv_core_top.f --Mdir obj_dir -o tb_sim \
  && ./obj_dir/tb_sim > sim.log 2>&1 \
  || echo "Simulation build or run ended with an error" >> sim.log

cat sim.log
grep -qx "Test passed" sim.log && exit 0 || exit 1
